/* irq_pkg.sv */
/*
  Shared constants and types of the machine-mode interrupt unit.
  Only lines 3, 7, 11 and 16-31 are legal; the rest are reserved.
  Register offsets are 5-bit byte addresses on a 32-bit AXI4-Lite bus.
*/
package irq_pkg;

  // --------------------
  // Interrupt constants
  localparam int unsigned NUM_IRQ         = 32;
  localparam logic [31:0] VALID_IRQ_MASK  = 32'hffff_0888;
  localparam logic [31:0] WFI_INSTR       = 32'h1050_0073;
  localparam int unsigned WFI_SLEEP_DELAY = 6;
  localparam int unsigned WFI_CNT_W       = $clog2(WFI_SLEEP_DELAY + 1);

  // MSTATUS bit positions
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;

  // --------------------
  // Plain vector types
  typedef logic [NUM_IRQ-1:0]   irq_vec_t;
  typedef logic [4:0]           irq_id_t;
  typedef logic [31:0]          xlen_t;
  typedef logic [4:0]           axil_addr_t;
  typedef logic [3:0]           axil_strb_t;
  typedef logic [1:0]           axil_resp_t;
  typedef logic [29:0]          mtvec_base_t;
  typedef logic [WFI_CNT_W-1:0] wfi_cnt_t;

  // Register map
  localparam axil_addr_t ADDR_MSTATUS = 5'h00;
  localparam axil_addr_t ADDR_MIE     = 5'h04;
  localparam axil_addr_t ADDR_MIP     = 5'h08;
  localparam axil_addr_t ADDR_MCAUSE  = 5'h0C;
  localparam axil_addr_t ADDR_MTVEC   = 5'h10;

  // AXI responses
  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  // --------------------
  // Bus and datapath structs
  typedef struct packed {
    logic       aw_valid;
    axil_addr_t aw_addr;
    logic       w_valid;
    xlen_t      w_data;
    axil_strb_t w_strb;
    logic       b_ready;
    logic       ar_valid;
    axil_addr_t ar_addr;
    logic       r_ready;
  } axil_req_t;

  typedef struct packed {
    logic       aw_ready;
    logic       w_ready;
    logic       b_valid;
    axil_resp_t b_resp;
    logic       ar_ready;
    logic       r_valid;
    xlen_t      r_data;
    axil_resp_t r_resp;
  } axil_rsp_t;

  typedef struct packed {
    irq_vec_t    mie;
    logic        mstatus_mie;
    mtvec_base_t mtvec_base;
    logic        mtvec_vectored;
  } irq_cfg_t;

  typedef struct packed {
    logic    take;
    irq_id_t id;
    xlen_t   pc;
  } irq_trap_t;

  // Sleep controller states
  typedef enum logic [1:0] {
    WFI_AWAKE,
    WFI_WAIT,
    WFI_ASLEEP
  } wfi_state_e;

endpackage

/* irq_csr_regs.sv */
/*
  AXI4-Lite register block with one outstanding response per channel.
  Unmapped addresses answer SLVERR; MIP and MCAUSE ignore writes.
  A trap take wins over mret and over a same-cycle MSTATUS write.
*/
module irq_csr_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  irq_pkg::axil_req_t axil_req_i,
  output irq_pkg::axil_rsp_t axil_rsp_o,
  input  irq_pkg::irq_vec_t  mip_i,
  input  irq_pkg::irq_trap_t trap_i,
  input  logic               mret_i,
  output irq_pkg::irq_cfg_t  cfg_o
);
  import irq_pkg::*;

  // Architectural state
  logic       mstatus_mie_q;
  logic       mstatus_mpie_q;
  irq_vec_t   mie_q;
  xlen_t      mtvec_q;
  logic       mcause_irq_q;
  irq_id_t    mcause_id_q;

  // Response holding
  logic       b_valid_q;
  axil_resp_t b_resp_q;
  logic       r_valid_q;
  xlen_t      r_data_q;
  axil_resp_t r_resp_q;

  logic       wr_accept;
  logic       rd_accept;
  logic       wr_hit;
  xlen_t      mstatus_rd;
  xlen_t      mcause_rd;
  xlen_t      wr_mstatus;
  xlen_t      wr_mie;
  xlen_t      wr_mtvec;
  xlen_t      rd_data;
  axil_resp_t rd_resp;

  // Byte lanes with strobe set take the new data
  function automatic xlen_t merge_strb(xlen_t old_val, xlen_t new_val, axil_strb_t strb);
    xlen_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  // --------------------
  // Channel handshakes
  assign wr_accept = axil_req_i.aw_valid & axil_req_i.w_valid & ~b_valid_q;
  assign rd_accept = axil_req_i.ar_valid & ~r_valid_q;

  always_comb begin
    case (axil_req_i.aw_addr)
      ADDR_MSTATUS, ADDR_MIE, ADDR_MIP, ADDR_MCAUSE, ADDR_MTVEC: wr_hit = 1'b1;
      default: wr_hit = 1'b0;
    endcase
  end

  // Read views of the packed registers
  always_comb begin
    mstatus_rd                   = '0;
    mstatus_rd[MSTATUS_MIE_BIT]  = mstatus_mie_q;
    mstatus_rd[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
  end

  assign mcause_rd = {mcause_irq_q, 26'b0, mcause_id_q};

  // Strobed write values
  assign wr_mstatus = merge_strb(mstatus_rd, axil_req_i.w_data, axil_req_i.w_strb);
  assign wr_mie     = merge_strb(mie_q, axil_req_i.w_data, axil_req_i.w_strb);
  assign wr_mtvec   = merge_strb(mtvec_q, axil_req_i.w_data, axil_req_i.w_strb);

  // Read mux, data 0 on error
  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (axil_req_i.ar_addr)
      ADDR_MSTATUS: rd_data = mstatus_rd;
      ADDR_MIE:     rd_data = mie_q;
      ADDR_MIP:     rd_data = mip_i;
      ADDR_MCAUSE:  rd_data = mcause_rd;
      ADDR_MTVEC:   rd_data = mtvec_q;
      default:      rd_resp = RESP_SLVERR;
    endcase
  end

  // Valid flags held until the master takes them
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_accept) begin
        b_valid_q <= 1'b1;
      end else if (axil_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
      if (rd_accept) begin
        r_valid_q <= 1'b1;
      end else if (axil_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Response payload
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      b_resp_q <= RESP_OKAY;
      r_data_q <= '0;
      r_resp_q <= RESP_OKAY;
    end else begin
      if (wr_accept) begin
        b_resp_q <= wr_hit ? RESP_OKAY : RESP_SLVERR;
      end
      if (rd_accept) begin
        r_data_q <= rd_data;
        r_resp_q <= rd_resp;
      end
    end
  end

  // --------------------
  // CSR updates
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mie_q          <= '0;
      mtvec_q        <= '0;
      mcause_irq_q   <= 1'b0;
      mcause_id_q    <= '0;
    end else begin
      // Trap entry saves and clears the global enable
      if (trap_i.take) begin
        mstatus_mpie_q <= mstatus_mie_q;
        mstatus_mie_q  <= 1'b0;
        mcause_irq_q   <= 1'b1;
        mcause_id_q    <= trap_i.id;
      end else if (mret_i) begin
        mstatus_mie_q  <= mstatus_mpie_q;
        mstatus_mpie_q <= 1'b1;
      end else if (wr_accept && axil_req_i.aw_addr == ADDR_MSTATUS) begin
        mstatus_mie_q  <= wr_mstatus[MSTATUS_MIE_BIT];
        mstatus_mpie_q <= wr_mstatus[MSTATUS_MPIE_BIT];
      end
      // Reserved enable bits stay 0
      if (wr_accept && axil_req_i.aw_addr == ADDR_MIE) begin
        mie_q <= wr_mie & VALID_IRQ_MASK;
      end
      // Modes 2 and 3 are rejected, whole register kept
      if (wr_accept && axil_req_i.aw_addr == ADDR_MTVEC && !wr_mtvec[1]) begin
        mtvec_q <= wr_mtvec;
      end
    end
  end

  // --------------------
  // Outputs
  assign axil_rsp_o.aw_ready = wr_accept;
  assign axil_rsp_o.w_ready  = wr_accept;
  assign axil_rsp_o.b_valid  = b_valid_q;
  assign axil_rsp_o.b_resp   = b_resp_q;
  assign axil_rsp_o.ar_ready = rd_accept;
  assign axil_rsp_o.r_valid  = r_valid_q;
  assign axil_rsp_o.r_data   = r_data_q;
  assign axil_rsp_o.r_resp   = r_resp_q;

  assign cfg_o.mie            = mie_q;
  assign cfg_o.mstatus_mie    = mstatus_mie_q;
  assign cfg_o.mtvec_base     = mtvec_q[31:2];
  assign cfg_o.mtvec_vectored = mtvec_q[0];

endmodule

/* irq_pending.sv */
/*
  Pending register, one cycle behind irq_i.
  Reserved lines are masked off before sampling.
*/
module irq_pending (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  irq_pkg::irq_vec_t irq_i,
  input  irq_pkg::irq_cfg_t cfg_i,
  output irq_pkg::irq_vec_t mip_o,
  output irq_pkg::irq_vec_t pend_en_o
);
  import irq_pkg::*;

  irq_vec_t mip_q;

  // --------------------
  // Sample legal lines every cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & VALID_IRQ_MASK;
    end
  end

  assign mip_o = mip_q;

  // Pending and locally enabled
  // Global enable is applied later, at the trap offer
  assign pend_en_o = mip_q & cfg_i.mie;

endmodule

/* irq_arbiter.sv */
/*
  Fixed-priority arbiter: 31 down to 16, then 11, 3, 7.
  The candidate is registered and tracks the winner every cycle,
  so a stalled offer carries the winner of the cycle before acceptance.
*/
module irq_arbiter (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  irq_pkg::irq_vec_t  pend_en_i,
  input  irq_pkg::irq_cfg_t  cfg_i,
  input  logic               core_ready_i,
  output irq_pkg::irq_trap_t trap_o
);
  import irq_pkg::*;

  logic    win_valid;
  irq_id_t win_id;
  logic    cand_valid_q;
  irq_id_t cand_id_q;
  xlen_t   base_addr;
  xlen_t   vec_offset;

  // --------------------
  // Winner selection
  // Lowest priority is assigned first, later hits override
  always_comb begin
    win_valid = 1'b0;
    win_id    = '0;
    if (pend_en_i[7]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(7);
    end
    if (pend_en_i[3]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(3);
    end
    if (pend_en_i[11]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(11);
    end
    // Platform lines, higher number wins
    for (int i = 16; i < NUM_IRQ; i++) begin
      if (pend_en_i[i]) begin
        win_valid = 1'b1;
        win_id    = irq_id_t'(i);
      end
    end
  end

  // Candidate register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cand_valid_q <= 1'b0;
      cand_id_q    <= '0;
    end else begin
      cand_valid_q <= win_valid;
      cand_id_q    <= win_id;
    end
  end

  // --------------------
  // Trap target
  assign base_addr  = {cfg_i.mtvec_base, 2'b00};
  // Vectored mode adds 4 bytes per id
  assign vec_offset = cfg_i.mtvec_vectored ? xlen_t'({cand_id_q, 2'b00}) : '0;

  // Offer, accepted in the same cycle when the core is ready
  // The register block clears MIE on that edge, so take is one cycle
  assign trap_o.take = cand_valid_q & cfg_i.mstatus_mie & core_ready_i;
  assign trap_o.id   = cand_id_q;
  assign trap_o.pc   = base_addr + vec_offset;

endmodule

/* irq_wfi_ctrl.sv */
/*
  WFI sleep controller. A valid, not-killed WFI in decode puts the core
  to sleep WFI_SLEEP_DELAY cycles later. Any pending-enabled line or a
  debug request wakes it, whatever the global interrupt enable.
*/
module irq_wfi_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              id_instr_valid_i,
  input  irq_pkg::xlen_t    id_instr_i,
  input  logic              branch_kill_i,
  input  logic              debug_req_i,
  input  irq_pkg::irq_vec_t pend_en_i,
  output logic              core_sleep_o
);
  import irq_pkg::*;

  wfi_state_e state_q;
  wfi_cnt_t   cnt_q;
  logic       wfi_dec;
  logic       wake;

  // --------------------
  // Decode and wake conditions
  assign wfi_dec = id_instr_valid_i & (id_instr_i == WFI_INSTR) & ~branch_kill_i;
  assign wake    = (|pend_en_i) | debug_req_i;

  // --------------------
  // Sleep FSM
  // The decode cycle counts as the first delay cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WFI_AWAKE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        WFI_AWAKE: begin
          if (wfi_dec && !wake) begin
            state_q <= WFI_WAIT;
            cnt_q   <= wfi_cnt_t'(WFI_SLEEP_DELAY - 1);
          end
        end
        WFI_WAIT: begin
          if (wake) begin
            state_q <= WFI_AWAKE;
          end else if (cnt_q == wfi_cnt_t'(1)) begin
            state_q <= WFI_ASLEEP;
          end else begin
            cnt_q <= cnt_q - wfi_cnt_t'(1);
          end
        end
        WFI_ASLEEP: begin
          // Wake on the next edge
          if (wake) begin
            state_q <= WFI_AWAKE;
          end
        end
        default: state_q <= WFI_AWAKE;
      endcase
    end
  end

  assign core_sleep_o = (state_q == WFI_ASLEEP);

endmodule

/* irq_unit_top.sv */
/*
  Machine-mode interrupt unit top. Single clock, async active-low reset.
  irq_i reaches irq_take_o two cycles later when all enables are set.
*/
module irq_unit_top (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  irq_pkg::irq_vec_t  irq_i,
  input  irq_pkg::axil_req_t axil_req_i,
  output irq_pkg::axil_rsp_t axil_rsp_o,
  input  logic               core_ready_i,
  input  logic               mret_i,
  input  logic               id_instr_valid_i,
  input  irq_pkg::xlen_t     id_instr_i,
  input  logic               branch_kill_i,
  input  logic               debug_req_i,
  output logic               irq_take_o,
  output irq_pkg::irq_id_t   irq_id_o,
  output irq_pkg::xlen_t     irq_pc_o,
  output logic               core_sleep_o
);
  import irq_pkg::*;

  // --------------------
  // Internal nets
  irq_cfg_t  cfg;
  irq_vec_t  mip;
  irq_vec_t  pend_en;
  irq_trap_t trap;

  // Registers and AXI4-Lite slave
  irq_csr_regs u_csr_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .mip_i      (mip),
    .trap_i     (trap),
    .mret_i     (mret_i),
    .cfg_o      (cfg)
  );

  irq_pending u_pending (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .irq_i     (irq_i),
    .cfg_i     (cfg),
    .mip_o     (mip),
    .pend_en_o (pend_en)
  );

  irq_arbiter u_arbiter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .pend_en_i    (pend_en),
    .cfg_i        (cfg),
    .core_ready_i (core_ready_i),
    .trap_o       (trap)
  );

  // Sleep control sees only pending-enabled lines
  irq_wfi_ctrl u_wfi_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .id_instr_valid_i (id_instr_valid_i),
    .id_instr_i       (id_instr_i),
    .branch_kill_i    (branch_kill_i),
    .debug_req_i      (debug_req_i),
    .pend_en_i        (pend_en),
    .core_sleep_o     (core_sleep_o)
  );

  // Trap interface to the core
  assign irq_take_o = trap.take;
  assign irq_id_o   = trap.id;
  assign irq_pc_o   = trap.pc;

endmodule

/* tb_irq_unit.sv */
/*
  Directed testbench for the interrupt unit top level.
  Inputs change 5 units after the rising edge; outputs are checked on the
  falling edge. AXI4-Lite strobes are always full words here.
*/
module tb_irq_unit;
  import irq_pkg::*;

  // Summed test length with a wide margin
  localparam int WATCHDOG_CYCLES = 20000;
  localparam int HS_LIMIT        = 50;

  logic      clk_i;
  logic      rst_ni;
  irq_vec_t  irq;
  axil_req_t req;
  axil_rsp_t rsp;
  logic      core_ready;
  logic      mret;
  logic      instr_valid;
  xlen_t     instr;
  logic      kill;
  logic      debug_req;
  logic      take;
  irq_id_t   take_id;
  xlen_t     take_pc;
  logic      sleep;
  int        errors;
  int        seed;
  int        take_cnt;

  irq_unit_top dut_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .irq_i            (irq),
    .axil_req_i       (req),
    .axil_rsp_o       (rsp),
    .core_ready_i     (core_ready),
    .mret_i           (mret),
    .id_instr_valid_i (instr_valid),
    .id_instr_i       (instr),
    .branch_kill_i    (kill),
    .debug_req_i      (debug_req),
    .irq_take_o       (take),
    .irq_id_o         (take_id),
    .irq_pc_o         (take_pc),
    .core_sleep_o     (sleep)
  );

  initial clk_i = 1'b0;
  always #20 clk_i = ~clk_i;

  // Accepted traps, counted on the falling edge
  always @(negedge clk_i) begin
    if (take) take_cnt++;
  end

  // --------------------
  // Compare tasks
  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_vec(input string name, input irq_vec_t exp, input irq_vec_t act);
    if (act !== exp) begin
      $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_id(input string name, input irq_id_t exp, input irq_id_t act);
    if (act !== exp) begin
      $display("FAILED t=%0t %s expected %0d got %0d", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_resp(input string name, input axil_resp_t exp, input axil_resp_t act);
    if (act !== exp) begin
      $display("FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
      errors++;
    end
  endtask

  // Expected winner in the order 31 down to 16, then 11, 3, 7
  function automatic irq_id_t expected_winner(irq_vec_t v);
    for (int i = 31; i >= 16; i--) begin
      if (v[i]) return irq_id_t'(i);
    end
    if (v[11]) return irq_id_t'(11);
    if (v[3]) return irq_id_t'(3);
    if (v[7]) return irq_id_t'(7);
    return '0;
  endfunction

  // --------------------
  // Stimulus helpers
  task automatic tick();
    @(posedge clk_i);
    #5;
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  task automatic axil_write(input axil_addr_t addr, input xlen_t data, output axil_resp_t resp);
    int n;
    tick();
    req.aw_valid = 1'b1;
    req.aw_addr  = addr;
    req.w_valid  = 1'b1;
    req.w_data   = data;
    req.w_strb   = 4'hf;
    req.b_ready  = 1'b0;
    n = 0;
    @(negedge clk_i);
    while (!rsp.aw_ready && n < HS_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!rsp.aw_ready) begin
      $display("Write to address %h was never accepted", addr);
      errors++;
    end else begin
      check_bit("w_ready", 1'b1, rsp.w_ready);
    end
    tick();
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
    req.b_ready  = 1'b1;
    n = 0;
    @(negedge clk_i);
    while (!rsp.b_valid && n < HS_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!rsp.b_valid) begin
      $display("Write to address %h never returned a response", addr);
      errors++;
    end
    resp = rsp.b_resp;
    tick();
    req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output xlen_t data, output axil_resp_t resp);
    int n;
    tick();
    req.ar_valid = 1'b1;
    req.ar_addr  = addr;
    req.r_ready  = 1'b0;
    n = 0;
    @(negedge clk_i);
    while (!rsp.ar_ready && n < HS_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!rsp.ar_ready) begin
      $display("Read of address %h was never accepted", addr);
      errors++;
    end
    tick();
    req.ar_valid = 1'b0;
    req.r_ready  = 1'b1;
    n = 0;
    @(negedge clk_i);
    while (!rsp.r_valid && n < HS_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (!rsp.r_valid) begin
      $display("Read of address %h never returned data", addr);
      errors++;
    end
    data = rsp.r_data;
    resp = rsp.r_resp;
    tick();
    req.r_ready = 1'b0;
  endtask

  task automatic write_reg(input axil_addr_t addr, input xlen_t data);
    axil_resp_t r;
    axil_write(addr, data, r);
    check_resp("b_resp", RESP_OKAY, r);
  endtask

  task automatic read_word(input axil_addr_t addr, input xlen_t exp, input string name);
    xlen_t      d;
    axil_resp_t r;
    axil_read(addr, d, r);
    check_resp("r_resp", RESP_OKAY, r);
    check_word(name, exp, d);
  endtask

  task automatic read_vec(input axil_addr_t addr, input irq_vec_t exp, input string name);
    xlen_t      d;
    axil_resp_t r;
    axil_read(addr, d, r);
    check_resp("r_resp", RESP_OKAY, r);
    check_vec(name, exp, irq_vec_t'(d));
  endtask

  // Take pulses on the 3rd falling edge after the lines are applied
  task automatic expect_take(input irq_vec_t m, input irq_id_t id, input xlen_t pc);
    tick();
    irq = m;
    @(negedge clk_i);
    check_bit("irq_take_o", 1'b0, take);
    @(negedge clk_i);
    check_bit("irq_take_o", 1'b0, take);
    @(negedge clk_i);
    check_bit("irq_take_o", 1'b1, take);
    check_id("irq_id_o", id, take_id);
    check_word("irq_pc_o", pc, take_pc);
    @(negedge clk_i);
    check_bit("irq_take_o", 1'b0, take);
  endtask

  // Sleep follows a WFI in decode by 6 cycles
  task automatic wfi_to_sleep();
    tick();
    instr_valid = 1'b1;
    instr       = WFI_INSTR;
    for (int i = 0; i < 6; i++) begin
      @(negedge clk_i);
      check_bit("core_sleep_o", 1'b0, sleep);
      tick();
      instr_valid = 1'b0;
      instr       = '0;
    end
    @(negedge clk_i);
    check_bit("core_sleep_o", 1'b1, sleep);
  endtask

  // --------------------
  // Tests
  task automatic test_registers();
    xlen_t      d;
    axil_resp_t r;
    check_bit("irq_take_o", 1'b0, take);
    check_bit("core_sleep_o", 1'b0, sleep);
    check_bit("b_valid", 1'b0, rsp.b_valid);
    check_bit("r_valid", 1'b0, rsp.r_valid);
    read_word(ADDR_MSTATUS, '0, "MSTATUS");
    read_vec(ADDR_MIE, '0, "MIE");
    read_vec(ADDR_MIP, '0, "MIP");
    read_word(ADDR_MCAUSE, '0, "MCAUSE");
    read_word(ADDR_MTVEC, '0, "MTVEC");
    // Reserved enables read back 0
    write_reg(ADDR_MIE, 32'hffff_ffff);
    read_vec(ADDR_MIE, VALID_IRQ_MASK, "MIE");
    // Mode 2 write is dropped
    write_reg(ADDR_MTVEC, 32'h0000_1000);
    write_reg(ADDR_MTVEC, 32'h0000_2002);
    read_word(ADDR_MTVEC, 32'h0000_1000, "MTVEC");
    tick();
    irq = 32'h0000_0888;
    write_reg(ADDR_MIP, 32'hffff_ffff);
    read_vec(ADDR_MIP, 32'h0000_0888, "MIP");
    // Unmapped offset
    axil_write(5'h14, 32'hdead_beef, r);
    check_resp("b_resp", RESP_SLVERR, r);
    axil_read(5'h14, d, r);
    check_resp("r_resp", RESP_SLVERR, r);
    check_word("r_data", '0, d);
    tick();
    irq = '0;
  endtask

  task automatic test_pending();
    irq_vec_t v;
    for (int k = 0; k < 20; k++) begin
      tick();
      v   = irq_vec_t'($random(seed));
      irq = v;
      read_vec(ADDR_MIP, v & VALID_IRQ_MASK, "MIP");
    end
    tick();
    irq = '0;
  endtask

  task automatic test_trap_entry();
    irq_vec_t m;
    irq_id_t  id;
    xlen_t    exp_pc;
    tick();
    irq        = '0;
    core_ready = 1'b1;
    write_reg(ADDR_MIE, VALID_IRQ_MASK);
    for (int k = 0; k < 16; k++) begin
      if (k == 0) write_reg(ADDR_MTVEC, 32'h0000_4000);
      if (k == 8) write_reg(ADDR_MTVEC, 32'h0000_8101);
      m = irq_vec_t'($random(seed)) & VALID_IRQ_MASK;
      // Odd rounds use only lines 3, 7 and 11
      if (k % 2 == 1) m = m & 32'h0000_0888;
      if (m == '0) m = 32'h0000_0008;
      id     = expected_winner(m);
      exp_pc = (k < 8) ? 32'h0000_4000 : 32'h0000_8100 + 4 * xlen_t'(id);
      tick();
      irq = '0;
      idle(2);
      write_reg(ADDR_MSTATUS, 32'h0000_0008);
      expect_take(m, id, exp_pc);
      tick();
      irq = '0;
      read_word(ADDR_MCAUSE, {1'b1, 26'b0, id}, "MCAUSE");
      read_word(ADDR_MSTATUS, 32'h0000_0080, "MSTATUS");
    end
  endtask

  task automatic test_mask_and_return();
    int cnt;
    tick();
    irq = '0;
    write_reg(ADDR_MIE, '0);
    write_reg(ADDR_MSTATUS, 32'h0000_0008);
    cnt = take_cnt;
    tick();
    irq = 32'h0010_0000;
    idle(5);
    // Line enabled, global enable off, MPIE set
    write_reg(ADDR_MSTATUS, 32'h0000_0080);
    write_reg(ADDR_MIE, 32'h0010_0000);
    idle(4);
    check_word("irq_take_o count", xlen_t'(cnt), xlen_t'(take_cnt));
    mret = 1'b1;
    @(negedge clk_i);
    check_bit("irq_take_o", 1'b0, take);
    tick();
    mret = 1'b0;
    @(negedge clk_i);
    check_bit("irq_take_o", 1'b1, take);
    check_id("irq_id_o", irq_id_t'(20), take_id);
    @(negedge clk_i);
    check_bit("irq_take_o", 1'b0, take);
    tick();
    irq = '0;
    read_word(ADDR_MCAUSE, 32'h8000_0014, "MCAUSE");
    read_word(ADDR_MSTATUS, 32'h0000_0080, "MSTATUS");
  endtask

  task automatic test_backpressure();
    int cnt;
    tick();
    irq        = '0;
    core_ready = 1'b0;
    write_reg(ADDR_MIE, VALID_IRQ_MASK);
    write_reg(ADDR_MSTATUS, 32'h0000_0008);
    cnt = take_cnt;
    tick();
    irq = 32'h0000_0008;
    repeat (4) begin
      @(negedge clk_i);
      check_bit("irq_take_o", 1'b0, take);
    end
    // Line 25 arrives during the stall
    tick();
    irq = 32'h0200_0008;
    idle(3);
    check_word("irq_take_o count", xlen_t'(cnt), xlen_t'(take_cnt));
    core_ready = 1'b1;
    @(negedge clk_i);
    check_bit("irq_take_o", 1'b1, take);
    check_id("irq_id_o", irq_id_t'(25), take_id);
    @(negedge clk_i);
    check_bit("irq_take_o", 1'b0, take);
    tick();
    irq = '0;
  endtask

  task automatic test_sleep();
    int cnt;
    tick();
    irq = '0;
    write_reg(ADDR_MSTATUS, '0);
    write_reg(ADDR_MIE, VALID_IRQ_MASK);
    idle(2);
    cnt = take_cnt;
    wfi_to_sleep();
    // Reserved line 0 never wakes
    tick();
    irq = 32'h0000_0001;
    repeat (3) begin
      @(negedge clk_i);
      check_bit("core_sleep_o", 1'b1, sleep);
    end
    tick();
    irq = 32'h0000_0009;
    @(negedge clk_i);
    check_bit("core_sleep_o", 1'b1, sleep);
    @(negedge clk_i);
    check_bit("core_sleep_o", 1'b1, sleep);
    @(negedge clk_i);
    check_bit("core_sleep_o", 1'b0, sleep);
    // Killed WFI is ignored
    tick();
    irq = '0;
    idle(3);
    instr_valid = 1'b1;
    instr       = WFI_INSTR;
    kill        = 1'b1;
    tick();
    instr_valid = 1'b0;
    kill        = 1'b0;
    repeat (8) begin
      @(negedge clk_i);
      check_bit("core_sleep_o", 1'b0, sleep);
    end
    wfi_to_sleep();
    tick();
    debug_req = 1'b1;
    @(negedge clk_i);
    check_bit("core_sleep_o", 1'b1, sleep);
    @(negedge clk_i);
    check_bit("core_sleep_o", 1'b0, sleep);
    tick();
    debug_req = 1'b0;
    check_word("irq_take_o count", xlen_t'(cnt), xlen_t'(take_cnt));
  endtask

  // --------------------
  // Main sequence
  initial begin
    errors      = 0;
    seed        = 41;
    take_cnt    = 0;
    rst_ni      = 1'b0;
    irq         = '0;
    req         = '0;
    core_ready  = 1'b1;
    mret        = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    kill        = 1'b0;
    debug_req   = 1'b0;
    repeat (16) @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    test_registers();
    test_pending();
    test_trap_entry();
    test_mask_and_return();
    test_backpressure();
    test_sleep();
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog against a stalled handshake
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, a test stalled, %0d errors so far",
             WATCHDOG_CYCLES, errors);
    $display("Regression failed");
    $finish;
  end

endmodule

/* compile.f */
irq_pkg.sv
irq_csr_regs.sv
irq_pending.sv
irq_arbiter.sv
irq_wfi_ctrl.sv
irq_unit_top.sv
tb_irq_unit.sv
